// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= uart_tx_bank_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+src
src/uart_pkg.sv
src/uart_clock_divider.sv
src/uart_transmitter.sv
src/uart_tx_dispatch.sv
src/uart_tx_bank.sv
test/uart_tx_bank_tb.sv

// ==== src/uart_clock_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_clock_divider #(
    parameter int clk_hz = `UART_CLK_HZ,
    parameter int baud_rate = `UART_BAUD_RATE
) (
    input wire logic clk,
    input wire logic reset_n,
    output logic clock_edge
);

    localparam int divisor = clk_hz / baud_rate;
    localparam int count_bits = $clog2(divisor);

    logic [count_bits-1:0] count;

    assign clock_edge = count == count_bits'(divisor - 1);

    // The reset cycle is the first clock of the period.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= count_bits'(1);
        end else if (clock_edge) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) clock_edge |=> !clock_edge);

endmodule

`default_nettype wire

// ==== src/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// System clock in Hz.
`define UART_CLK_HZ 1152000

// Serial bit rate that gives 10 clocks per bit at the clock above.
`define UART_BAUD_RATE 115200

// Number of transmit channels in the bank.
`define UART_NUM_CHANNELS 4

`endif

// ==== src/uart_pkg.sv ====
`default_nettype none

`include "uart_config.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start_bit,
        tx_data_bit,
        tx_stop_bit
    } tx_state_t;

    localparam int channel_bits = (`UART_NUM_CHANNELS > 1) ? $clog2(`UART_NUM_CHANNELS) : 1;

    typedef logic [channel_bits-1:0] channel_t;

endpackage

`default_nettype wire

// ==== src/uart_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_transmitter
    import uart_pkg::*;
(
    input wire logic reset_n,
    input wire logic clk,

    input wire logic [7:0] write_data,
    input wire logic write_req,
    output logic ready,

    output logic tx
);

    tx_state_t state;
    tx_state_t state_next;

    logic [7:0] data_latch;
    logic [2:0] bit_index;
    logic [2:0] bit_index_next;
    logic tx_next;

    logic baud_soft_reset;
    logic divider_reset_n;
    logic baud_edge;
    logic bit_done;

    assign ready = state == tx_idle;

    // Divider restarts at every frame start.
    assign divider_reset_n = reset_n & ~baud_soft_reset;

    uart_clock_divider #(
        .clk_hz(`UART_CLK_HZ),
        .baud_rate(`UART_BAUD_RATE)
    ) baud_divider (
        .clk(clk),
        .reset_n(divider_reset_n),
        .clock_edge(baud_edge)
    );

    assign bit_done = baud_edge & ~baud_soft_reset; // Stale tick in the restart cycle.

    always_comb begin
        state_next = state;
        bit_index_next = bit_index;
        tx_next = 1'b1;

        case (state)
            tx_idle: begin
                if (write_req) begin
                    state_next = tx_start_bit;
                end
            end

            tx_start_bit: begin
                tx_next = 1'b0;
                if (bit_done) begin
                    state_next = tx_data_bit;
                    bit_index_next = 3'd0;
                end
            end

            tx_data_bit: begin
                tx_next = data_latch[bit_index]; // LSB first.
                if (bit_done) begin
                    if (bit_index == 3'd7) begin
                        state_next = tx_stop_bit;
                    end else begin
                        bit_index_next = bit_index + 3'd1;
                    end
                end
            end

            tx_stop_bit: begin
                if (bit_done) begin
                    state_next = tx_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= tx_idle;
            bit_index <= 3'd0;
            baud_soft_reset <= 1'b0;
            tx <= 1'b1;
        end else begin
            state <= state_next;
            bit_index <= bit_index_next;
            baud_soft_reset <= (state == tx_idle) && write_req;
            tx <= tx_next;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == tx_idle) && write_req) begin
            data_latch <= write_data;
        end
    end

    // The dispatcher only requests an idle channel.
    assert property (@(posedge clk) disable iff (!reset_n) write_req |-> ready);

endmodule

`default_nettype wire

// ==== src/uart_tx_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx_bank
    import uart_pkg::*;
(
    input wire logic clk,
    input wire logic reset_n,

    input wire logic [7:0] write_data,
    input wire channel_t write_channel,
    input wire logic write_req,
    output logic write_ready,

    output wire logic [`UART_NUM_CHANNELS-1:0] tx
);

    logic [7:0] chan_data;
    logic [`UART_NUM_CHANNELS-1:0] chan_req;
    wire logic [`UART_NUM_CHANNELS-1:0] chan_ready;

    uart_tx_dispatch dispatch_i (
        .clk(clk),
        .reset_n(reset_n),
        .write_data(write_data),
        .write_channel(write_channel),
        .write_req(write_req),
        .write_ready(write_ready),
        .chan_data(chan_data),
        .chan_req(chan_req),
        .chan_ready(chan_ready)
    );

    for (genvar i = 0; i < `UART_NUM_CHANNELS; i++) begin : g_channel
        uart_transmitter transmitter_i (
            .reset_n(reset_n),
            .clk(clk),
            .write_data(chan_data), // Only the requested channel takes the shared byte.
            .write_req(chan_req[i]),
            .ready(chan_ready[i]),
            .tx(tx[i])
        );
    end

endmodule

`default_nettype wire

// ==== src/uart_tx_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx_dispatch
    import uart_pkg::*;
(
    input wire logic clk,
    input wire logic reset_n,

    input wire logic [7:0] write_data,
    input wire channel_t write_channel,
    input wire logic write_req,
    output logic write_ready,

    output logic [7:0] chan_data,
    output logic [`UART_NUM_CHANNELS-1:0] chan_req,
    input wire logic [`UART_NUM_CHANNELS-1:0] chan_ready
);

    localparam int num_channels = `UART_NUM_CHANNELS;

    typedef logic [num_channels-1:0] chan_vec_t;

    logic hold_valid;
    logic [7:0] hold_data;
    channel_t hold_channel;

    logic accept;
    logic write_free;
    logic hold_free;
    logic hold_fire;

    assign write_ready = ~hold_valid;
    assign accept = write_req & write_ready;

    // A channel with a pulse in flight still reads ready for one cycle.
    assign write_free = chan_ready[write_channel] & ~chan_req[write_channel];
    assign hold_free = chan_ready[hold_channel] & ~chan_req[hold_channel];
    assign hold_fire = hold_valid & hold_free;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            chan_req <= '0;
            hold_valid <= 1'b0;
        end else begin
            chan_req <= '0;
            if (hold_fire) begin
                chan_req <= chan_vec_t'(1) << hold_channel;
            end else if (accept && write_free) begin
                chan_req <= chan_vec_t'(1) << write_channel;
            end

            if (accept && !write_free) begin
                hold_valid <= 1'b1; // Park until the channel frees up.
            end else if (hold_valid && chan_req[hold_channel]) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold_fire) begin
            chan_data <= hold_data;
        end else if (accept && write_free) begin
            chan_data <= write_data;
        end

        if (accept && !write_free) begin
            hold_data <= write_data;
            hold_channel <= write_channel;
        end
    end

    // Requests go to one channel at a time and only to an idle one.
    assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(chan_req) && ((chan_req & ~chan_ready) == '0));

endmodule

`default_nettype wire

// ==== test/uart_tx_bank_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx_bank_tb
    import uart_pkg::*;
();

    localparam int num_channels = `UART_NUM_CHANNELS;
    localparam int clocks_per_bit = `UART_CLK_HZ / `UART_BAUD_RATE;
    localparam int clock_period_ns = 10;
    localparam int total_frames = 1 + 4 + 2 + 40;
    localparam int watchdog_ns = (total_frames * 120 + 20) * clocks_per_bit * clock_period_ns;

    logic clk;
    logic reset_n;
    logic [7:0] write_data;
    channel_t write_channel;
    logic write_req;
    logic write_ready;
    logic [num_channels-1:0] tx;

    logic [7:0] exp_queue [num_channels][$];
    logic [7:0] rx_queue [num_channels][$];
    int frame_errors [num_channels] = '{default: 0};
    logic [31:0] rng_state = 32'h6a7c_3164;

    uart_tx_bank uart_tx_bank_i (
        .clk(clk),
        .reset_n(reset_n),
        .write_data(write_data),
        .write_channel(write_channel),
        .write_req(write_req),
        .write_ready(write_ready),
        .tx(tx)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Serial decoders sample tx on the falling edge where it is stable.
    for (genvar c = 0; c < num_channels; c++) begin : g_decoder
        initial begin
            logic [7:0] shift;
            shift = 8'h00;
            wait (reset_n === 1'b1);
            forever begin
                @(negedge clk);
                if (tx[c] === 1'b0) begin
                    repeat (clocks_per_bit / 2 - 1) @(negedge clk); // Middle of the start bit.
                    if (tx[c] !== 1'b0) begin
                        frame_errors[c]++;
                    end
                    for (int b = 0; b < 8; b++) begin
                        repeat (clocks_per_bit) @(negedge clk);
                        shift[b] = tx[c]; // LSB first.
                    end
                    repeat (clocks_per_bit) @(negedge clk);
                    if (tx[c] !== 1'b1) begin
                        frame_errors[c]++;
                    end
                    rx_queue[c].push_back(shift);
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Holds the request for exactly one accepting edge.
    task automatic write_byte(input channel_t channel, input logic [7:0] data);
        while (write_ready !== 1'b1) begin
            @(negedge clk);
        end
        write_data = data;
        write_channel = channel;
        write_req = 1'b1;
        exp_queue[channel].push_back(data);
        @(negedge clk);
        write_req = 1'b0;
    endtask

    task automatic wait_until_drained();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = (write_ready === 1'b1) && (tx === '1);
            for (int c = 0; c < num_channels; c++) begin
                if (rx_queue[c].size() < exp_queue[c].size()) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    task automatic check_channels();
        for (int c = 0; c < num_channels; c++) begin
            check_value($sformatf("frame_errors[%0d]", c), 32'(frame_errors[c]), 32'd0);
            check_value($sformatf("rx_queue[%0d].size", c), 32'(rx_queue[c].size()),
                        32'(exp_queue[c].size()));
            for (int i = 0; i < exp_queue[c].size(); i++) begin
                check_value($sformatf("rx_queue[%0d][%0d]", c, i), 32'(rx_queue[c][i]),
                            32'(exp_queue[c][i]));
            end
        end
    endtask

    task automatic test_reset_state();
        check_value("tx", 32'(tx), 32'((1 << num_channels) - 1));
        check_value("write_ready", 32'(write_ready), 32'd1);
        check_channels();
    endtask

    task automatic test_single_byte();
        write_byte(channel_t'(0), 8'hA5);
        wait_until_drained();
        check_channels();
    endtask

    task automatic test_all_channels();
        logic [7:0] bytes [4];
        bytes = '{8'h3C, 8'hC3, 8'h5A, 8'h0F};
        for (int c = 0; c < num_channels; c++) begin
            write_byte(channel_t'(c), bytes[c % 4]);
        end
        while (tx[num_channels-1] !== 1'b0) begin
            @(negedge clk);
        end
        check_value("tx", 32'(tx), 32'd0); // All start bits at once.
        wait_until_drained();
        check_channels();
    endtask

    task automatic test_back_to_back();
        write_byte(channel_t'(2), 8'h96);
        write_byte(channel_t'(2), 8'h69);
        check_value("write_ready", 32'(write_ready), 32'd0);
        while (write_ready !== 1'b1) begin
            @(negedge clk);
        end
        // First frame is complete before the port reopens.
        check_value("rx_queue[2].size", 32'(rx_queue[2].size()), 32'(exp_queue[2].size() - 1));
        check_value("tx[2]", 32'(tx[2]), 32'd1);
        wait_until_drained();
        check_channels();
    endtask

    task automatic test_random_traffic();
        channel_t channel;
        logic [7:0] data;
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift(rng_state);
            channel = channel_t'(rng_state % 32'(num_channels));
            data = rng_state[15:8];
            write_byte(channel, data);
        end
        wait_until_drained();
        check_channels();
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset_n = 1'b0;
        write_data = 8'h00;
        write_channel = channel_t'(0);
        write_req = 1'b0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_single_byte();
        test_all_channels();
        test_back_to_back();
        test_random_traffic();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
